// File: Bender.yml
package:
  name: prbs_pins

sources:
  # packages first
  - prbs_cfg_pkg.sv
  - pin_map_pkg.sv
  # design
  - lock_qualifier.sv
  - prbs_wide.sv
  - pattern_engine.sv
  - pin_driver.sv
  - prbs_pins_top.sv
  # testbench
  - target: test
    files:
      - tb_prbs_pins.sv

// File: lock_qualifier.sv
`timescale 1ns/1ps
`default_nettype none

module lock_qualifier
	import prbs_cfg_pkg::*;
(
	input logic clock,
	input logic rst_n,
	input logic locked, // async level from the clock manager
	output logic run // qualified lock
);

	logic [sync_stages-1:0] lock_sync; // synchronizer chain
	logic lock_s; // synced lock level
	logic [hold_width-1:0] hold_cnt; // consecutive synced lock cycles
	logic hold_done; // hold count reached

	assign lock_s = lock_sync[sync_stages-1]; // last stage
	assign hold_done = (hold_cnt == hold_width'(lock_hold_cycles));

	// two flops, locked crosses in here
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			lock_sync <= '0;
		end else begin
			lock_sync <= {lock_sync[sync_stages-2:0], locked}; // shift in at bit 0
		end
	end

	// count synced lock, saturate at the hold length
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			hold_cnt <= '0;
		end else if (!lock_s) begin
			hold_cnt <= '0; // any loss restarts the hold
		end else if (!hold_done) begin
			hold_cnt <= hold_cnt + 1'b1;
		end
	end

	// granted once the hold is full
	// synced low drops it on the same edge, counter clears one later
	assign run = hold_done & lock_s;

endmodule

`default_nettype wire

// File: pattern_engine.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_engine
	import prbs_cfg_pkg::*;
	import pin_map_pkg::*;
(
	input logic clock,
	input logic rst_n,
	input logic run, // qualified lock
	input logic mode_counter, // 1 = counter view, 0 = prbs
	output pin_word_u pattern_byte // registered output byte
);

	logic advance; // lfsr step enable
	logic [byte_width-1:0] rand_byte; // prbs byte from the generator
	logic [counter_width-1:0] counter; // free-running while run
	pin_word_u next_byte; // byte to register this edge

	assign advance = run; // generator runs with the lock

	prbs_wide prbs0 (
		.clock(clock),
		.rst_n(rst_n),
		.advance(advance),
		.rand_byte(rand_byte)
	);

	// counter restarts from zero on every new lock
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			counter <= '0;
		end else if (!run) begin
			counter <= '0;
		end else begin
			counter <= counter + 1'b1;
		end
	end

	// pick the source, union written through the matching view
	always_comb begin
		next_byte = '0;
		if (mode_counter) begin
			next_byte.pins.sma_gpio_p = counter[2]; // fast bits on the sma pins
			next_byte.pins.sma_gpio_n = counter[1];
			next_byte.pins.sma_clock_p = counter[0];
			next_byte.pins.sma_clock_n = 1'b0; // unused in counter view
			next_byte.pins.led = counter[counter_width-1:led_lsb]; // slow top bits
		end else begin
			next_byte.pattern = rand_byte; // raw prbs byte
		end
	end

	// one register stage, zero while not running
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pattern_byte <= '0;
		end else if (!run) begin
			pattern_byte <= '0;
		end else begin
			pattern_byte <= next_byte;
		end
	end

endmodule

`default_nettype wire

// File: pin_driver.sv
`timescale 1ns/1ps
`default_nettype none

module pin_driver
	import pin_map_pkg::*;
(
	input logic clock,
	input logic rst_n,
	input pin_word_u pattern_byte, // byte from the engine
	output logic sma_gpio_p,
	output logic sma_gpio_n,
	output logic sma_clock_p,
	output logic sma_clock_n,
	output logic [led_width-1:0] led
);

	pin_word_u pin_q; // output register, stands in for the iob flops

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pin_q <= '0; // pins low out of reset
		end else begin
			pin_q <= pattern_byte;
		end
	end

	// field view straight to the board pins
	assign sma_gpio_p = pin_q.pins.sma_gpio_p;
	assign sma_gpio_n = pin_q.pins.sma_gpio_n;
	assign sma_clock_p = pin_q.pins.sma_clock_p;
	assign sma_clock_n = pin_q.pins.sma_clock_n;
	assign led = pin_q.pins.led; // led 3 is the msb

endmodule

`default_nettype wire

// File: pin_map_pkg.sv
`default_nettype none

package pin_map_pkg;

	localparam int led_width = 4; // board leds

	// field view, msb first as wired on the board
	typedef struct packed {
		logic sma_gpio_p; // bit 7
		logic sma_gpio_n; // bit 6
		logic sma_clock_p; // bit 5
		logic sma_clock_n; // bit 4
		logic [led_width-1:0] led; // bits 3..0, led 3 on top
	} pin_fields_t;

	// one output byte, seen raw or per pin
	typedef union packed {
		logic [7:0] pattern; // raw pattern byte
		pin_fields_t pins; // named pin fields
	} pin_word_u;

endpackage

`default_nettype wire

// File: prbs_cfg_pkg.sv
`default_nettype none

package prbs_cfg_pkg;

	// lfsr generator
	localparam int lfsr_width = 32; // state bits
	localparam int tap_a = 28; // first feedback tap, counted from 1
	localparam int tap_b = 31; // second feedback tap, counted from 1
	localparam logic [lfsr_width-1:0] lfsr_seed = 32'h0000_0001; // loaded while idle

	// output rate
	localparam int byte_width = 8; // pattern bits per clock

	// counter view
	localparam int counter_width = 27; // free-running counter size
	localparam int led_lsb = 23; // lowest counter bit on the leds

	// lock qualification
	localparam int lock_hold_cycles = 16; // synced lock cycles before run
	localparam int sync_stages = 2; // synchronizer depth
	localparam int hold_width = $clog2(lock_hold_cycles + 1); // hold counter bits

endpackage

`default_nettype wire

// File: prbs_pins_top.sv
`timescale 1ns/1ps
`default_nettype none

module prbs_pins_top
	import pin_map_pkg::*;
(
	input logic clock, // generated clock from the clock manager
	input logic rst_n,
	input logic locked, // clock manager lock, async
	input logic mode_counter, // 1 = counter view
	output logic sma_gpio_p,
	output logic sma_gpio_n,
	output logic sma_clock_p,
	output logic sma_clock_n,
	output logic [led_width-1:0] led
);

	logic run; // qualified lock
	pin_word_u pattern_byte; // engine to output stage

	// input side
	lock_qualifier lockq0 (
		.clock(clock),
		.rst_n(rst_n),
		.locked(locked),
		.run(run)
	);

	// prbs or counter byte
	pattern_engine engine0 (
		.clock(clock),
		.rst_n(rst_n),
		.run(run),
		.mode_counter(mode_counter),
		.pattern_byte(pattern_byte)
	);

	// output register stage
	pin_driver pins0 (
		.clock(clock),
		.rst_n(rst_n),
		.pattern_byte(pattern_byte),
		.sma_gpio_p(sma_gpio_p),
		.sma_gpio_n(sma_gpio_n),
		.sma_clock_p(sma_clock_p),
		.sma_clock_n(sma_clock_n),
		.led(led)
	);

endmodule

`default_nettype wire

// File: prbs_wide.sv
`timescale 1ns/1ps
`default_nettype none

module prbs_wide
	import prbs_cfg_pkg::*;
(
	input logic clock,
	input logic rst_n,
	input logic advance, // step when high, reseed when low
	output logic [byte_width-1:0] rand_byte // feedback bits of this edge
);

	logic [lfsr_width-1:0] state; // fibonacci lfsr state
	logic [lfsr_width-1:0] step_state; // state after the unrolled steps
	logic [byte_width-1:0] step_byte; // feedback bits, first step on top
	logic fb; // feedback of one step

	// eight steps unrolled per clock
	always_comb begin
		step_state = state;
		step_byte = '0;
		fb = 1'b0;
		for (int i = byte_width - 1; i >= 0; i--) begin
			fb = step_state[tap_a-1] ^ step_state[tap_b-1]; // taps counted from 1
			step_state = {step_state[lfsr_width-2:0], fb}; // shift left, fb into bit 0
			step_byte[i] = fb; // bit 7 is the first step
		end
	end

	// state register, seed whenever idle
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= lfsr_seed;
		end else if (!advance) begin
			state <= lfsr_seed; // restart the sequence
		end else begin
			state <= step_state;
		end
	end

	// output byte
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rand_byte <= '0;
		end else if (!advance) begin
			rand_byte <= '0; // quiet while idle
		end else begin
			rand_byte <= step_byte;
		end
	end

endmodule

`default_nettype wire

// File: tb_prbs_pins.sv
`timescale 1ns/1ps
`default_nettype none

module tb_prbs_pins
	import prbs_cfg_pkg::*;
	import pin_map_pkg::*;
();

	localparam int clk_period = 100; // ns
	localparam int reset_cycles = 8; // rst_n low this long
	localparam int n_rows = 13; // stimulus table rows
	localparam int rand_base = 8; // shortest random row
	localparam int rand_bits = 4; // lfsr bits per random length
	localparam int watchdog_margin = 50; // spare cycles

	logic clock;
	logic rst_n;
	logic locked;
	logic mode_counter;
	logic sma_gpio_p;
	logic sma_gpio_n;
	logic sma_clock_p;
	logic sma_clock_n;
	logic [led_width-1:0] led;

	// stimulus table with one column per array
	// locked, mode_counter, cycles held (0 = random length)
	bit row_locked [n_rows] = '{0, 1, 0, 1, 1, 1, 1, 0, 1, 0, 1, 1, 0};
	bit row_mode [n_rows] = '{0, 0, 0, 0, 1, 0, 1, 1, 1, 0, 0, 1, 0};
	int row_cycles [n_rows] = '{6, 10, 6, 60, 0, 0, 0, 8, 40, 8, 50, 0, 6};

	logic [31:0] rng = 32'h28e3_fcf6; // row length generator

	// reference model state
	logic m_sync1; // first sync stage
	logic m_sync2; // second sync stage
	int m_hold; // synced lock cycles seen
	logic m_run; // model run level
	logic [lfsr_width-1:0] m_state; // reference lfsr
	logic [byte_width-1:0] m_rbyte; // prbs byte stage
	logic [counter_width-1:0] m_count; // counter model
	pin_word_u m_pattern; // pattern byte stage
	pin_word_u m_pins; // pin register stage

	prbs_pins_top dut0 (
		.clock(clock),
		.rst_n(rst_n),
		.locked(locked),
		.mode_counter(mode_counter),
		.sma_gpio_p(sma_gpio_p),
		.sma_gpio_n(sma_gpio_n),
		.sma_clock_p(sma_clock_p),
		.sma_clock_n(sma_clock_n),
		.led(led)
	);

	initial begin : clock_gen
		clock = 1'b0;
		forever #(clk_period / 2) clock = ~clock;
	end

	// taps 32 22 2 1 and one step per bit
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic draw_bits(input int n, output int value);
		value = 0;
		for (int k = 0; k < n; k++) begin
			rng = lfsr_next(rng);
			value = (value << 1) | rng[0]; // newest bit at the bottom
		end
	endtask

	// eight fibonacci steps returning {next state, byte}
	function automatic logic [lfsr_width+byte_width-1:0] ref_prbs_step(
		input logic [lfsr_width-1:0] st
	);
		logic [lfsr_width-1:0] s;
		logic [byte_width-1:0] b;
		logic fb;
		s = st;
		b = '0;
		for (int k = 0; k < byte_width; k++) begin
			fb = s[tap_a-1] ^ s[tap_b-1]; // taps counted from 1
			s = {s[lfsr_width-2:0], fb};
			b = {b[byte_width-2:0], fb}; // first step ends in bit 7
		end
		return {s, b};
	endfunction

	// counter view as gpio_p gpio_n clock_p clock_n and leds
	function automatic pin_word_u counter_fields(input logic [counter_width-1:0] c);
		pin_word_u w;
		w.pattern = {c[2], c[1], c[0], 1'b0, c[counter_width-1:led_lsb]};
		return w;
	endfunction

	// one rising edge of the model with inputs read before this edge's drive
	task automatic model_step();
		logic [lfsr_width+byte_width-1:0] nxt;
		if (!rst_n) begin
			m_sync1 = 1'b0;
			m_sync2 = 1'b0;
			m_hold = 0;
			m_run = 1'b0;
			m_state = lfsr_seed;
			m_rbyte = '0;
			m_count = '0;
			m_pattern = '0;
			m_pins = '0;
		end else begin
			m_pins = m_pattern; // output stage one edge behind
			if (!m_run) begin
				m_pattern = '0; // quiet without lock
			end else if (mode_counter) begin
				m_pattern = counter_fields(m_count);
			end else begin
				m_pattern.pattern = m_rbyte;
			end
			if (!m_run) begin
				m_count = '0; // restart on next lock
				m_state = lfsr_seed;
				m_rbyte = '0;
			end else begin
				m_count = m_count + 1'b1;
				nxt = ref_prbs_step(m_state);
				m_state = nxt[lfsr_width+byte_width-1:byte_width];
				m_rbyte = nxt[byte_width-1:0];
			end
			// lock qualifier model
			if (!m_sync2) begin
				m_hold = 0;
			end else if (m_hold < lock_hold_cycles) begin
				m_hold++;
			end
			m_sync2 = m_sync1;
			m_sync1 = locked;
			m_run = m_sync2 && (m_hold == lock_hold_cycles);
		end
	endtask

	task automatic compare_value(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic check_pins();
		compare_value("sma_gpio_p", sma_gpio_p, m_pins.pins.sma_gpio_p);
		compare_value("sma_gpio_n", sma_gpio_n, m_pins.pins.sma_gpio_n);
		compare_value("sma_clock_p", sma_clock_p, m_pins.pins.sma_clock_p);
		compare_value("sma_clock_n", sma_clock_n, m_pins.pins.sma_clock_n);
		compare_value("led", led, m_pins.pins.led);
	endtask

	// drive on the rising edge and check on the falling edge
	task automatic tick(input logic rst_v, input logic lock_v, input logic mode_v);
		@(posedge clock);
		model_step();
		rst_n <= rst_v;
		locked <= lock_v;
		mode_counter <= mode_v;
		@(negedge clock);
		check_pins();
	endtask

	initial begin : stimulus
		int len;
		rst_n = 1'b0;
		locked = 1'b0;
		mode_counter = 1'b0;
		for (int i = 0; i < reset_cycles; i++) begin
			tick(i == reset_cycles - 1, 1'b0, 1'b0); // release on the last one
		end
		for (int r = 0; r < n_rows; r++) begin
			if (row_cycles[r] == 0) begin
				draw_bits(rand_bits, len);
				len = rand_base + len;
			end else begin
				len = row_cycles[r];
			end
			repeat (len) tick(1'b1, row_locked[r], row_mode[r]);
		end
		$display("PASS: all tests");
		$finish;
	end

	// bound from the table with random rows at their longest
	initial begin : watchdog
		longint limit;
		limit = reset_cycles + watchdog_margin;
		for (int r = 0; r < n_rows; r++) begin
			if (row_cycles[r] == 0) begin
				limit += rand_base + (1 << rand_bits) - 1;
			end else begin
				limit += row_cycles[r];
			end
		end
		#(limit * clk_period);
		$display("watchdog: run did not finish within %0d clock cycles", limit);
		$display("FAIL: see errors above");
		$fatal(1);
	end

endmodule

`default_nettype wire

// File: vlog.f
prbs_cfg_pkg.sv
pin_map_pkg.sv
lock_qualifier.sv
prbs_wide.sv
pattern_engine.sv
pin_driver.sv
prbs_pins_top.sv
tb_prbs_pins.sv
